// File: rtl/vctr_pkg.sv
package vctr_pkg;

  // Vector length and element count width
  localparam int LEN_W = 10;

  typedef logic [LEN_W-1:0] len_t;

  // Element-wise operations, all modulo 2^DATA_WIDTH
  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_MAX = 2'd2,  // Unsigned compare
    OP_MIN = 2'd3   // Unsigned compare
  } vctr_op_t;

  // Job command, sampled while start is high in idle
  typedef struct packed {
    vctr_op_t op;
    len_t     length;
  } vctr_cmd_t;

  typedef enum logic [1:0] {
    ST_IDLE    = 2'd0,
    ST_COMPUTE = 2'd1,
    ST_DONE    = 2'd2
  } vctr_state_t;

endpackage

// File: rtl/hsid_fifo.sv
`timescale 1ns/10ps

module hsid_fifo #(
  parameter int DATA_WIDTH   = 16,
  parameter int DEPTH        = 8,   // Power of two
  parameter int AF_THRESHOLD = 6
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wr_en,
  input  logic                  rd_en,
  input  logic [DATA_WIDTH-1:0] data_in,
  output logic [DATA_WIDTH-1:0] data_out,
  output logic                  full,
  output logic                  almost_full,
  output logic                  empty
);

  localparam int AW = $clog2(DEPTH);
  localparam int CW = $clog2(DEPTH + 1);

  logic [DATA_WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]         wr_ptr;
  logic [AW-1:0]         rd_ptr;
  logic [CW-1:0]         count;
  logic                  do_wr;
  logic                  do_rd;

  assign do_wr = wr_en && !full;   // Overflowing writes are dropped
  assign do_rd = rd_en && !empty;

  // Storage array
  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= data_in;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;  // Wraps at DEPTH
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Idle or both at once
      endcase
    end
  end

  // Head word shows without a read strobe
  assign data_out    = mem[rd_ptr];
  assign full        = (count == CW'(DEPTH));
  assign empty       = (count == '0);
  assign almost_full = (count >= CW'(AF_THRESHOLD));

  // Producers must honor the flags
  a_no_wr_full : assert property (
    @(posedge clk) disable iff (!rst_n) !(wr_en && full)
  ) else $error("hsid_fifo write while full");

  a_no_rd_empty : assert property (
    @(posedge clk) disable iff (!rst_n) !(rd_en && empty)
  ) else $error("hsid_fifo read while empty");

endmodule

// File: rtl/vctr_ctrl.sv
`timescale 1ns/10ps

module vctr_ctrl
  import vctr_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      start,
  input  vctr_cmd_t cmd,
  input  logic      v1_empty,
  input  logic      v2_empty,
  input  logic      out_almost_full,
  input  logic      res_wr,
  input  logic      data_out_empty,
  output logic      issue,
  output vctr_op_t  op,
  output logic      state_ready,
  output logic      idle,
  output logic      done
);

  vctr_state_t state;
  vctr_state_t state_nxt;
  vctr_cmd_t   cmd_q;      // Latched job
  len_t        issued;     // Pairs sent to the pipeline
  logic [1:0]  in_flight;  // Issued but not yet written

  // Room in the output FIFO is checked against results still in flight
  assign issue = (state == ST_COMPUTE) && !v1_empty && !v2_empty &&
                 (issued < cmd_q.length) && !out_almost_full;

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE:    if (start) state_nxt = ST_COMPUTE;
      ST_COMPUTE: if (issued == cmd_q.length && in_flight == 2'd0) state_nxt = ST_DONE;
      ST_DONE:    if (data_out_empty) state_nxt = ST_IDLE;  // Wait for host drain
      default:    state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= ST_IDLE;
      cmd_q     <= '0;
      issued    <= '0;
      in_flight <= 2'd0;
    end else begin
      state <= state_nxt;
      if (state == ST_IDLE && start) begin
        cmd_q  <= cmd;
        issued <= '0;
      end else if (issue) begin
        issued <= issued + 1'b1;
      end
      case ({issue, res_wr})
        2'b10:   in_flight <= in_flight + 1'b1;
        2'b01:   in_flight <= in_flight - 1'b1;
        default: in_flight <= in_flight;
      endcase
    end
  end

  assign op          = cmd_q.op;
  assign idle        = (state == ST_IDLE);
  assign state_ready = (state == ST_COMPUTE);
  assign done        = (state == ST_DONE);

  // Pipeline depth of the ALU bounds this
  a_in_flight_max : assert property (
    @(posedge clk) disable iff (!rst_n) in_flight <= 2'd2
  ) else $error("vctr_ctrl in-flight count above 2");

  a_issued_max : assert property (
    @(posedge clk) disable iff (!rst_n) issued <= cmd_q.length
  ) else $error("vctr_ctrl issued count above job length");

endmodule

// File: rtl/vctr_alu.sv
`timescale 1ns/10ps

module vctr_alu
  import vctr_pkg::*;
#(
  parameter int DATA_WIDTH = 16
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  issue,
  input  vctr_op_t              op,
  input  logic [DATA_WIDTH-1:0] a,
  input  logic [DATA_WIDTH-1:0] b,
  output logic [DATA_WIDTH-1:0] res,
  output logic                  res_wr
);

  logic [DATA_WIDTH-1:0] a_q;
  logic [DATA_WIDTH-1:0] b_q;
  vctr_op_t              op_q;
  logic                  s1_valid;
  logic [DATA_WIDTH-1:0] res_nxt;

  // Stage 1 captures the FIFO heads on the pop edge
  always_ff @(posedge clk) begin
    if (issue) begin
      a_q  <= a;
      b_q  <= b;
      op_q <= op;
    end
  end

  always_comb begin
    case (op_q)
      OP_ADD:  res_nxt = a_q + b_q;
      OP_SUB:  res_nxt = a_q - b_q;   // Wraps on borrow
      OP_MAX:  res_nxt = (a_q > b_q) ? a_q : b_q;
      default: res_nxt = (a_q < b_q) ? a_q : b_q;
    endcase
  end

  // Stage 2 result register
  always_ff @(posedge clk) begin
    if (s1_valid) begin
      res <= res_nxt;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      res_wr   <= 1'b0;
    end else begin
      s1_valid <= issue;
      res_wr   <= s1_valid;   // One-cycle write pulse
    end
  end

  a_wr_after_issue : assert property (
    @(posedge clk) disable iff (!rst_n) issue |-> ##2 res_wr
  ) else $error("vctr_alu missing res_wr two cycles after issue");

  a_no_spurious_wr : assert property (
    @(posedge clk) disable iff (!rst_n) !issue |-> ##2 !res_wr
  ) else $error("vctr_alu res_wr without issue two cycles before");

endmodule

// File: rtl/vctr_fifo_strm.sv
`timescale 1ns/10ps

module vctr_fifo_strm
  import vctr_pkg::*;
#(
  parameter int DATA_WIDTH    = 16,
  parameter int BUFFER_LENGTH = 8   // Power of two, at least 4
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  data_in_v1_en,
  input  logic [DATA_WIDTH-1:0] data_in_v1,
  output logic                  data_in_v1_full,
  input  logic                  data_in_v2_en,
  input  logic [DATA_WIDTH-1:0] data_in_v2,
  output logic                  data_in_v2_full,
  input  logic                  data_out_en,
  output logic [DATA_WIDTH-1:0] data_out,
  output logic                  data_out_empty,
  input  vctr_cmd_t             cmd,
  input  logic                  start,
  output logic                  done,
  output logic                  idle,
  output logic                  ready
);

  logic [DATA_WIDTH-1:0] v1_head;
  logic [DATA_WIDTH-1:0] v2_head;
  logic [DATA_WIDTH-1:0] res;
  logic                  v1_empty;
  logic                  v2_empty;
  logic                  out_almost_full;
  logic                  issue;
  logic                  res_wr;
  vctr_op_t              op;

  // Host pushes only count while a job runs
  hsid_fifo #(
    .DATA_WIDTH  (DATA_WIDTH),
    .DEPTH       (BUFFER_LENGTH),
    .AF_THRESHOLD(BUFFER_LENGTH - 1)
  ) vctr_in_1 (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_en      (data_in_v1_en && ready && !data_in_v1_full),
    .rd_en      (issue),
    .data_in    (data_in_v1),
    .data_out   (v1_head),
    .full       (data_in_v1_full),
    .almost_full(),
    .empty      (v1_empty)
  );

  hsid_fifo #(
    .DATA_WIDTH  (DATA_WIDTH),
    .DEPTH       (BUFFER_LENGTH),
    .AF_THRESHOLD(BUFFER_LENGTH - 1)
  ) vctr_in_2 (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_en      (data_in_v2_en && ready && !data_in_v2_full),
    .rd_en      (issue),
    .data_in    (data_in_v2),
    .data_out   (v2_head),
    .full       (data_in_v2_full),
    .almost_full(),
    .empty      (v2_empty)
  );

  // Two slots kept free for results already in the pipeline
  hsid_fifo #(
    .DATA_WIDTH  (DATA_WIDTH),
    .DEPTH       (BUFFER_LENGTH),
    .AF_THRESHOLD(BUFFER_LENGTH - 2)
  ) vctr_out (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_en      (res_wr),
    .rd_en      (data_out_en && !data_out_empty),
    .data_in    (res),
    .data_out   (data_out),
    .full       (),
    .almost_full(out_almost_full),
    .empty      (data_out_empty)
  );

  vctr_ctrl i_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .start          (start),
    .cmd            (cmd),
    .v1_empty       (v1_empty),
    .v2_empty       (v2_empty),
    .out_almost_full(out_almost_full),
    .res_wr         (res_wr),
    .data_out_empty (data_out_empty),
    .issue          (issue),
    .op             (op),
    .state_ready    (ready),
    .idle           (idle),
    .done           (done)
  );

  vctr_alu #(
    .DATA_WIDTH(DATA_WIDTH)
  ) i_alu (
    .clk   (clk),
    .rst_n (rst_n),
    .issue (issue),
    .op    (op),
    .a     (v1_head),
    .b     (v2_head),
    .res   (res),
    .res_wr(res_wr)
  );

endmodule

// File: sim/vctr_tb.sv
`timescale 1ns/10ps

module vctr_tb
  import vctr_pkg::*;
();

  localparam int DATA_WIDTH    = 16;
  localparam int BUFFER_LENGTH = 8;
  localparam int RAND_JOBS     = 20;
  localparam int NUM_JOBS      = RAND_JOBS + 3;  // Two back-pressure jobs and one empty job
  localparam int MAX_CYCLES    = 400 * NUM_JOBS + 500;
  localparam int MAX_LEN       = 40;

  typedef logic [DATA_WIDTH-1:0] word_t;

  logic      clk;
  logic      rst_n;
  logic      data_in_v1_en;
  word_t     data_in_v1;
  logic      data_in_v1_full;
  logic      data_in_v2_en;
  word_t     data_in_v2;
  logic      data_in_v2_full;
  logic      data_out_en;
  word_t     data_out;
  logic      data_out_empty;
  vctr_cmd_t cmd;
  logic      start;
  logic      done;
  logic      idle;
  logic      ready;

  logic [31:0] rng_state;
  word_t       exp_q[$];   // Expected results in output order
  int          checks;
  int          errors;
  int          cycles;

  vctr_fifo_strm #(
    .DATA_WIDTH   (DATA_WIDTH),
    .BUFFER_LENGTH(BUFFER_LENGTH)
  ) i_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_in_v1_en  (data_in_v1_en),
    .data_in_v1     (data_in_v1),
    .data_in_v1_full(data_in_v1_full),
    .data_in_v2_en  (data_in_v2_en),
    .data_in_v2     (data_in_v2),
    .data_in_v2_full(data_in_v2_full),
    .data_out_en    (data_out_en),
    .data_out       (data_out),
    .data_out_empty (data_out_empty),
    .cmd            (cmd),
    .start          (start),
    .done           (done),
    .idle           (idle),
    .ready          (ready)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;  // 20 ns period

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles", cycles);
      $display("%0d checks run, %0d errors", checks, errors);
      $display("Checks failed");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // True with a probability of pct percent
  function automatic logic chance(input int pct);
    logic [31:0] r;
    r = next_rand();
    return (r % 32'd100) < 32'(pct);
  endfunction

  // Wrap rules with unsigned compares
  function automatic word_t model_result(input vctr_op_t op, input word_t a, input word_t b);
    logic [DATA_WIDTH:0] wide;
    case (op)
      OP_ADD:  wide = {1'b0, a} + {1'b0, b};
      OP_SUB:  wide = {1'b0, a} + {1'b0, ~b} + (DATA_WIDTH+1)'(1);  // Two's complement
      OP_MAX:  wide = {1'b0, ((a >= b) ? a : b)};
      default: wide = {1'b0, ((a <= b) ? a : b)};
    endcase
    return wide[DATA_WIDTH-1:0];  // Carry dropped
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("Error: %s", what);
    end
  endtask

  task automatic tick();
    @(posedge clk);
    #2;
  endtask

  task automatic start_job(input vctr_op_t op, input int len);
    check_true(idle, "job started while the unit was not idle");
    cmd.op     = op;
    cmd.length = len_t'(len);
    start      = 1'b1;
    tick();
    start = 1'b0;
    check_true(ready, "ready did not follow start in idle");
    check_value("done", 32'(done), 32'h0);
  endtask

  // One job with host pushes and drains interleaved
  task automatic run_job(input vctr_op_t op, input int len, input logic stall_out);
    word_t       a_vec[MAX_LEN];
    word_t       b_vec[MAX_LEN];
    logic [31:0] r;
    int          n1;
    int          n2;
    int          nq;
    int          npop;
    int          job_cyc;
    logic        hold;
    word_t       held;
    logic        saw_full;
    logic        saw_done;
    logic        pop_ok;

    for (int i = 0; i < len; i++) begin
      r = next_rand();
      a_vec[i] = r[DATA_WIDTH-1:0];
      r = next_rand();
      b_vec[i] = r[DATA_WIDTH-1:0];
      if (chance(10)) begin
        b_vec[i] = a_vec[i];  // Equal operands now and then
      end
    end

    n1       = 0;
    n2       = 0;
    nq       = 0;
    npop     = 0;
    job_cyc  = 0;
    hold     = 1'b0;
    held     = '0;
    saw_full = 1'b0;
    saw_done = 1'b0;
    start_job(op, len);

    while (!idle) begin
      data_in_v1_en = 1'b0;
      data_in_v2_en = 1'b0;
      data_out_en   = 1'b0;
      saw_full = saw_full | data_in_v1_full | data_in_v2_full;
      if (done) begin
        saw_done = 1'b1;
        check_true(n1 == len && n2 == len, "done rose before all pairs were sent");
      end
      if (hold) begin
        check_true(!data_out_empty, "output emptied without a pop");
        check_value("data_out", 32'(data_out), 32'(held));  // Must hold while not popped
      end
      hold = 1'b0;

      if (!data_out_empty) begin
        pop_ok = stall_out ? (job_cyc % 64 >= 48) : 1'b1;  // Long stalls under back-pressure
        if (pop_ok && chance(stall_out ? 80 : 75)) begin
          data_out_en = 1'b1;
          if (exp_q.size() == 0) begin
            check_true(1'b0, "result appeared with none expected");
          end else begin
            check_value("data_out", 32'(data_out), 32'(exp_q.pop_front()));
          end
          npop++;
        end else begin
          hold = 1'b1;
          held = data_out;
        end
      end

      if (ready && n1 < len && !data_in_v1_full && chance(70)) begin
        data_in_v1_en = 1'b1;
        data_in_v1    = a_vec[n1];
        n1++;
      end
      if (ready && n2 < len && !data_in_v2_full && chance(70)) begin
        data_in_v2_en = 1'b1;
        data_in_v2    = b_vec[n2];
        n2++;
      end
      while (nq < n1 && nq < n2) begin
        exp_q.push_back(model_result(op, a_vec[nq], b_vec[nq]));  // Pair complete
        nq++;
      end

      job_cyc++;
      tick();
    end

    data_in_v1_en = 1'b0;
    data_in_v2_en = 1'b0;
    data_out_en   = 1'b0;
    check_true(saw_done, "done never rose before idle returned");
    check_value("result count", 32'(npop), 32'(len));
    check_true(exp_q.size() == 0, "expected results left over after the job");
    check_true(data_out_empty, "idle returned with the output not drained");
    if (stall_out) begin
      check_true(saw_full, "no input full flag rose under back-pressure");
    end
    tick();
    check_true(data_out_empty, "output appeared after the job ended");
  endtask

  initial begin
    logic [31:0] r;
    vctr_op_t    op;
    int          len;

    rst_n         = 1'b0;
    data_in_v1_en = 1'b0;
    data_in_v1    = '0;
    data_in_v2_en = 1'b0;
    data_in_v2    = '0;
    data_out_en   = 1'b0;
    cmd           = '0;
    start         = 1'b0;
    rng_state     = 32'h66fb_949a;
    checks        = 0;
    errors        = 0;
    cycles        = 0;

    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;

    check_value("idle", 32'(idle), 32'h1);
    check_value("ready", 32'(ready), 32'h0);
    check_value("done", 32'(done), 32'h0);
    check_value("data_out_empty", 32'(data_out_empty), 32'h1);
    check_value("data_in_v1_full", 32'(data_in_v1_full), 32'h0);
    check_value("data_in_v2_full", 32'(data_in_v2_full), 32'h0);
    tick();

    for (int j = 0; j < RAND_JOBS; j++) begin
      r   = next_rand();
      op  = (j < 4) ? vctr_op_t'(j[1:0]) : vctr_op_t'(r[9:8]);  // All ops early on
      r   = next_rand();
      len = 1 + int'(r % 32'(MAX_LEN));
      run_job(op, len, 1'b0);
    end

    run_job(OP_ADD, MAX_LEN, 1'b1);
    run_job(OP_SUB, MAX_LEN, 1'b1);
    run_job(OP_MAX, 0, 1'b0);  // Empty job

    $display("%0d checks run, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: build.f
rtl/vctr_pkg.sv
rtl/hsid_fifo.sv
rtl/vctr_ctrl.sv
rtl/vctr_alu.sv
rtl/vctr_fifo_strm.sv
sim/vctr_tb.sv

// File: build.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it once
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f build.f --top-module vctr_tb -o vctr_sim

out=$(./obj_dir/vctr_sim)
echo "$out"

# The run counts as passed only if the testbench said so
echo "$out" | grep -q "All checks passed"
